//--- icache_pkg.sv
/*
 Widths, address fields and types shared by the instruction cache.
 A line is one 128-bit refill word. CACHE_SIZE and NB_WAYS must be powers of two,
 with at least two sets per way.
*/
`default_nettype none

package icache_pkg;

   //////////////////////////////
   // Widths
   //////////////////////////////
   localparam int FETCH_ADDR_WIDTH  = 32;   // Core fetch address
   localparam int FETCH_DATA_WIDTH  = 32;   // Core fetch word
   localparam int REFILL_DATA_WIDTH = 128;  // One line, one L2 beat
   localparam int LINE_OFFSET_WIDTH = 4;    // Byte offset in a 16-byte line
   localparam int WORD_SEL_WIDTH    = 2;    // 32-bit word inside a line

   typedef logic [FETCH_ADDR_WIDTH-1:0]  fetch_addr_t;
   typedef logic [FETCH_DATA_WIDTH-1:0]  fetch_data_t;
   typedef logic [REFILL_DATA_WIDTH-1:0] line_data_t;

   // Controller FSM
   typedef enum logic [2:0] {
      IDLE,         // Waiting for fetch or flush
      LOOKUP,       // Tags and lines read, compare
      REFILL_REQ,   // Refill address held toward L2
      REFILL_WAIT,  // Waiting for the refill line
      FLUSH         // One cycle, all valid bits cleared
   } ctrl_state_t;

   //////////////////////////////
   // Address field sizes
   //////////////////////////////
   // Set index bits, 5 with 2 ways and 1 KiB
   function automatic int set_addr_width(input int nb_ways, input int cache_size);
      return $clog2(cache_size / nb_ways / (REFILL_DATA_WIDTH / 8));
   endfunction

   // Full tag, everything above set index
   function automatic int tag_width(input int nb_ways, input int cache_size);
      return FETCH_ADDR_WIDTH - LINE_OFFSET_WIDTH - set_addr_width(nb_ways, cache_size);
   endfunction

endpackage

`default_nettype wire

//--- icache_tag_store.sv
/*
 Tag and valid bits for every set and way, read for all ways at once.
 Read data shows up one cycle after rd_en_i. A flush clears all valid bits in one cycle.
*/
`timescale 1ns/1ps
`default_nettype none

module icache_tag_store
#(
   parameter int NB_WAYS   = 2,
   parameter int SET_WIDTH = 5,
   parameter int TAG_WIDTH = 23
)
(
   input  logic                                clk,
   input  logic                                rst_n_i,

   input  logic                                rd_en_i,
   input  logic [SET_WIDTH-1:0]                set_i,      // Read and write set
   input  logic [NB_WAYS-1:0]                  wr_way_i,   // One-hot way to write
   input  logic [TAG_WIDTH-1:0]                wdata_i,
   input  logic                                flush_i,

   output logic [NB_WAYS-1:0][TAG_WIDTH-1:0]   tag_o,
   output logic [NB_WAYS-1:0]                  valid_o
);

   localparam int NB_SETS = 2**SET_WIDTH;

   logic [TAG_WIDTH-1:0]             tag_q [NB_WAYS][NB_SETS];  // Tag array, no reset
   logic [NB_WAYS-1:0][NB_SETS-1:0]  valid_q;                   // Valid bit per way and set

   // Valid bits and their read register
   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         valid_q <= '0;
         valid_o <= '0;
      end
      else
      begin
         for (int w = 0; w < NB_WAYS; w++)
         begin
            if (rd_en_i)
               valid_o[w] <= valid_q[w][set_i];
            if (flush_i)
               valid_q[w] <= '0;                    // Flush wins over a write
            else if (wr_way_i[w])
               valid_q[w][set_i] <= 1'b1;
         end
      end
   end

   // Tag payload
   always_ff @(posedge clk)
   begin
      for (int w = 0; w < NB_WAYS; w++)
      begin
         if (wr_way_i[w])
            tag_q[w][set_i] <= wdata_i;
         if (rd_en_i)
            tag_o[w] <= tag_q[w][set_i];           // Old tag if same-cycle write
      end
   end

   a_wr_way_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
      $onehot0(wr_way_i))
      else $error("tag store written in more than one way");

endmodule

`default_nettype wire

//--- icache_data_store.sv
/*
 Line storage for every way, with a registered read of all ways at one set.
 No reset. A line is valid only through the tag store.
*/
`timescale 1ns/1ps
`default_nettype none

module icache_data_store import icache_pkg::*;
#(
   parameter int NB_WAYS   = 2,
   parameter int SET_WIDTH = 5
)
(
   input  logic                       clk,
   input  logic                       rd_en_i,
   input  logic [SET_WIDTH-1:0]       set_i,
   input  logic [NB_WAYS-1:0]         wr_way_i,   // One-hot, from the victim pointer
   input  line_data_t                 wdata_i,    // Refill line
   output line_data_t [NB_WAYS-1:0]   rdata_o     // All ways, one cycle after rd_en_i
);

   localparam int NB_SETS = 2**SET_WIDTH;

   line_data_t mem_q [NB_WAYS][NB_SETS];

   always_ff @(posedge clk)
   begin
      for (int w = 0; w < NB_WAYS; w++)
      begin
         if (wr_way_i[w])
            mem_q[w][set_i] <= wdata_i;
         if (rd_en_i)
            rdata_o[w] <= mem_q[w][set_i];
      end
   end

endmodule

`default_nettype wire

//--- refill_resp_fifo.sv
/*
 Two-entry buffer on the L2 refill response. The consumer is always ready,
 so an entry is popped in the cycle it shows on valid_o.
*/
`timescale 1ns/1ps
`default_nettype none

module refill_resp_fifo import icache_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n_i,

   input  logic        valid_i,   // L2 response strobe
   input  line_data_t  data_i,

   output logic        valid_o,   // Head entry present
   output line_data_t  data_o
);

   line_data_t  mem_q [2];
   logic        wr_ptr_q;
   logic        rd_ptr_q;
   logic [1:0]  count_q;      // 0 to 2 entries
   logic        full;
   logic        push;
   logic        pop;

   assign full    = (count_q == 2'd2);
   assign push    = valid_i && !full;
   assign pop     = valid_o;           // Consumer never stalls
   assign valid_o = (count_q != 2'd0);
   assign data_o  = mem_q[rd_ptr_q];

   //////////////////////////////
   // Pointers and count
   //////////////////////////////
   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_q <= 1'b0;
         rd_ptr_q <= 1'b0;
         count_q  <= 2'd0;
      end
      else
      begin
         if (push)
            wr_ptr_q <= ~wr_ptr_q;
         if (pop)
            rd_ptr_q <= ~rd_ptr_q;
         case ({push, pop})
            2'b10:   count_q <= count_q + 2'd1;
            2'b01:   count_q <= count_q - 2'd1;
            default: count_q <= count_q;          // Both or neither
         endcase
      end
   end

   // Entry storage
   always_ff @(posedge clk)
   begin
      if (push)
         mem_q[wr_ptr_q] <= data_i;
   end

   // L2 has no back-pressure on this path
   a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n_i)
      full |-> !valid_i)
      else $error("refill response while buffer full");

endmodule

`default_nettype wire

//--- icache_controller.sv
/*
 Cache FSM: lookup, hit compare, one outstanding miss refill, round-robin victim, flush, bypass.
 A hit returns the word the cycle after grant. Refill_req_o is combinational in LOOKUP on a miss.
 Bypass and flush requests are taken only in IDLE.
*/
`timescale 1ns/1ps
`default_nettype none

module icache_controller import icache_pkg::*;
#(
   parameter  int NB_WAYS    = 2,
   parameter  int CACHE_SIZE = 1024,
   localparam int SET_W      = set_addr_width(NB_WAYS, CACHE_SIZE),
   localparam int TAG_W      = tag_width(NB_WAYS, CACHE_SIZE)
)
(
   input  logic                            clk,
   input  logic                            rst_n_i,

   // Core fetch port
   input  logic                            fetch_req_i,
   input  fetch_addr_t                     fetch_addr_i,
   output logic                            fetch_gnt_o,
   output logic                            fetch_rvalid_o,
   output fetch_data_t                     fetch_rdata_o,

   // L2 address channel and buffered response
   output logic                            refill_req_o,
   output fetch_addr_t                     refill_addr_o,
   input  logic                            refill_gnt_i,
   input  logic                            resp_valid_i,
   input  line_data_t                      resp_data_i,

   // Control levels
   input  logic                            bypass_icache_i,
   output logic                            cache_is_bypassed_o,
   input  logic                            flush_icache_i,
   output logic                            cache_is_flushed_o,

   // Tag store
   output logic                            tag_rd_en_o,
   output logic [NB_WAYS-1:0]              tag_wr_way_o,
   output logic [SET_W-1:0]                tag_set_o,
   output logic [TAG_W-1:0]                tag_wdata_o,
   output logic                            tag_flush_o,
   input  logic [NB_WAYS-1:0]              tag_valid_i,
   input  logic [NB_WAYS-1:0][TAG_W-1:0]   tag_rdata_i,

   // Data store
   output logic                            data_rd_en_o,
   output logic [NB_WAYS-1:0]              data_wr_way_o,
   output logic [SET_W-1:0]                data_set_o,
   output line_data_t                      data_wdata_o,
   input  line_data_t [NB_WAYS-1:0]        data_rdata_i
);

   ctrl_state_t                state_q, state_d;
   fetch_addr_t                addr_q;           // Granted fetch address
   logic                       bypass_q;         // Bypass level seen in IDLE
   logic                       flushed_q;
   logic [NB_WAYS-1:0]         victim_q;         // One-hot round-robin pointer
   logic                       refill_rvalid_q;
   fetch_data_t                refill_word_q;

   logic [TAG_W-1:0]           addr_tag;
   logic [SET_W-1:0]           addr_set;
   logic [WORD_SEL_WIDTH-1:0]  word_sel;
   logic [NB_WAYS-1:0]         hit_way;
   logic                       hit;
   line_data_t                 hit_line;
   logic                       flush_pend;
   logic                       grant;
   logic                       resp_take;        // Line arrives in REFILL_WAIT
   logic                       alloc;            // ...and is written into the cache
   logic [SET_W-1:0]           store_set;

   // 32-bit word out of a line
   function automatic fetch_data_t pick_word(input line_data_t line,
                                             input logic [WORD_SEL_WIDTH-1:0] sel);
      return line[sel*FETCH_DATA_WIDTH +: FETCH_DATA_WIDTH];
   endfunction

   assign addr_tag = addr_q[FETCH_ADDR_WIDTH-1 -: TAG_W];
   assign addr_set = addr_q[LINE_OFFSET_WIDTH +: SET_W];
   assign word_sel = addr_q[LINE_OFFSET_WIDTH-1 -: WORD_SEL_WIDTH];

   //////////////////////////////
   // Hit compare
   //////////////////////////////
   always_comb
   begin
      hit_line = '0;
      for (int w = 0; w < NB_WAYS; w++)
      begin
         hit_way[w] = tag_valid_i[w] && (tag_rdata_i[w] == addr_tag);
         if (hit_way[w])
            hit_line = hit_line | data_rdata_i[w];   // At most one way
      end
   end

   assign hit        = |hit_way;
   assign flush_pend = flush_icache_i && !flushed_q;  // Already empty, nothing to do

   // Grant in IDLE, or back to back behind a hit
   always_comb
   begin
      case (state_q)
         IDLE:    grant = fetch_req_i && !flush_pend;
         LOOKUP:  grant = hit && fetch_req_i && !flush_pend && !bypass_icache_i;
         default: grant = 1'b0;
      endcase
   end

   //////////////////////////////
   // Next state
   //////////////////////////////
   always_comb
   begin
      state_d = state_q;
      case (state_q)
         IDLE:
         begin
            if (flush_pend)
               state_d = FLUSH;
            else if (grant)
               state_d = bypass_icache_i ? REFILL_REQ : LOOKUP;
         end
         LOOKUP:
         begin
            if (hit)
               state_d = grant ? LOOKUP : IDLE;
            else
               state_d = refill_gnt_i ? REFILL_WAIT : REFILL_REQ;  // Req already out
         end
         REFILL_REQ:
         begin
            if (refill_gnt_i)
               state_d = REFILL_WAIT;
         end
         REFILL_WAIT:
         begin
            if (resp_valid_i)
               state_d = IDLE;
         end
         default: state_d = IDLE;                     // FLUSH is one cycle
      endcase
   end

   assign resp_take = (state_q == REFILL_WAIT) && resp_valid_i;
   assign alloc     = resp_take && !bypass_q;         // Bypass never allocates
   assign store_set = alloc ? addr_set : fetch_addr_i[LINE_OFFSET_WIDTH +: SET_W];

   // Core side
   assign fetch_gnt_o    = grant;
   assign fetch_rvalid_o = ((state_q == LOOKUP) && hit) || refill_rvalid_q;
   assign fetch_rdata_o  = refill_rvalid_q ? refill_word_q : pick_word(hit_line, word_sel);

   // L2 side, line aligned
   assign refill_req_o  = (state_q == REFILL_REQ) || ((state_q == LOOKUP) && !hit);
   assign refill_addr_o = {addr_q[FETCH_ADDR_WIDTH-1:LINE_OFFSET_WIDTH],
                           {LINE_OFFSET_WIDTH{1'b0}}};

   // Stores
   assign tag_rd_en_o   = grant && !bypass_icache_i;
   assign data_rd_en_o  = grant && !bypass_icache_i;
   assign tag_set_o     = store_set;
   assign data_set_o    = store_set;
   assign tag_wr_way_o  = alloc ? victim_q : '0;
   assign data_wr_way_o = alloc ? victim_q : '0;
   assign tag_wdata_o   = addr_tag;
   assign data_wdata_o  = resp_data_i;
   assign tag_flush_o   = (state_q == FLUSH);

   assign cache_is_bypassed_o = bypass_q;
   assign cache_is_flushed_o  = flushed_q;

   //////////////////////////////
   // Control registers
   //////////////////////////////
   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state_q         <= IDLE;
         bypass_q        <= 1'b0;
         flushed_q       <= 1'b1;                     // Reset clears every valid bit
         victim_q        <= NB_WAYS'(1);
         refill_rvalid_q <= 1'b0;
      end
      else
      begin
         state_q         <= state_d;
         refill_rvalid_q <= resp_take;                // Word goes out one cycle later
         if (state_q == IDLE)
            bypass_q <= bypass_icache_i;
         if (state_q == FLUSH)
            flushed_q <= 1'b1;
         else if (alloc)
            flushed_q <= 1'b0;
         if (alloc)
            victim_q <= (victim_q << 1) | victim_q[NB_WAYS-1];  // Rotate
      end
   end

   // Payload
   always_ff @(posedge clk)
   begin
      if (grant)
         addr_q <= fetch_addr_i;
      if (resp_take)
         refill_word_q <= pick_word(resp_data_i, word_sel);
   end

   // Allocation keeps one copy per line, so a tag matches in one way only
   a_hit_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
      (state_q == LOOKUP) |-> $onehot0(hit_way))
      else $error("tag hit in more than one way");

endmodule

`default_nettype wire

//--- pri_icache.sv
/*
 Private instruction cache for one core. The refill address goes straight out,
 16-byte aligned. The L2 response passes through a two-entry buffer, and one miss
 is outstanding at a time.
*/
`timescale 1ns/1ps
`default_nettype none

module pri_icache import icache_pkg::*;
#(
   parameter  int NB_WAYS    = 2,      // Associativity
   parameter  int CACHE_SIZE = 1024,   // Bytes
   localparam int SET_W      = set_addr_width(NB_WAYS, CACHE_SIZE),
   localparam int TAG_W      = tag_width(NB_WAYS, CACHE_SIZE)
)
(
   input  logic         clk,
   input  logic         rst_n_i,

   // Core
   input  logic         fetch_req_i,
   input  fetch_addr_t  fetch_addr_i,
   output logic         fetch_gnt_o,
   output logic         fetch_rvalid_o,
   output fetch_data_t  fetch_rdata_o,

   // L2 refill
   output logic         refill_req_o,
   output fetch_addr_t  refill_addr_o,
   input  logic         refill_gnt_i,
   input  logic         refill_r_valid_i,
   input  line_data_t   refill_r_data_i,

   // Control and status
   input  logic         bypass_icache_i,
   input  logic         flush_icache_i,
   output logic         cache_is_bypassed_o,
   output logic         cache_is_flushed_o
);

   // Tag store
   logic                            tag_rd_en;
   logic [NB_WAYS-1:0]              tag_wr_way;
   logic [SET_W-1:0]                tag_set;
   logic [TAG_W-1:0]                tag_wdata;
   logic                            tag_flush;
   logic [NB_WAYS-1:0]              tag_valid;
   logic [NB_WAYS-1:0][TAG_W-1:0]   tag_rdata;

   // Data store
   logic                            data_rd_en;
   logic [NB_WAYS-1:0]              data_wr_way;
   logic [SET_W-1:0]                data_set;
   line_data_t                      data_wdata;
   line_data_t [NB_WAYS-1:0]        data_rdata;

   // Buffered refill response
   logic                            resp_valid;
   line_data_t                      resp_data;

   //////////////////////////////
   // Controller
   //////////////////////////////
   icache_controller
   #(
      .NB_WAYS             ( NB_WAYS             ),
      .CACHE_SIZE          ( CACHE_SIZE          )
   )
   i_controller
   (
      .clk                 ( clk                 ),
      .rst_n_i             ( rst_n_i             ),
      .fetch_req_i         ( fetch_req_i         ),
      .fetch_addr_i        ( fetch_addr_i        ),
      .fetch_gnt_o         ( fetch_gnt_o         ),
      .fetch_rvalid_o      ( fetch_rvalid_o      ),
      .fetch_rdata_o       ( fetch_rdata_o       ),
      .refill_req_o        ( refill_req_o        ),
      .refill_addr_o       ( refill_addr_o       ),
      .refill_gnt_i        ( refill_gnt_i        ),
      .resp_valid_i        ( resp_valid          ),
      .resp_data_i         ( resp_data           ),
      .bypass_icache_i     ( bypass_icache_i     ),
      .cache_is_bypassed_o ( cache_is_bypassed_o ),
      .flush_icache_i      ( flush_icache_i      ),
      .cache_is_flushed_o  ( cache_is_flushed_o  ),
      .tag_rd_en_o         ( tag_rd_en           ),
      .tag_wr_way_o        ( tag_wr_way          ),
      .tag_set_o           ( tag_set             ),
      .tag_wdata_o         ( tag_wdata           ),
      .tag_flush_o         ( tag_flush           ),
      .tag_valid_i         ( tag_valid           ),
      .tag_rdata_i         ( tag_rdata           ),
      .data_rd_en_o        ( data_rd_en          ),
      .data_wr_way_o       ( data_wr_way         ),
      .data_set_o          ( data_set            ),
      .data_wdata_o        ( data_wdata          ),
      .data_rdata_i        ( data_rdata          )
   );

   //////////////////////////////
   // Stores
   //////////////////////////////
   icache_tag_store
   #(
      .NB_WAYS   ( NB_WAYS    ),
      .SET_WIDTH ( SET_W      ),
      .TAG_WIDTH ( TAG_W      )
   )
   i_tag_store
   (
      .clk       ( clk        ),
      .rst_n_i   ( rst_n_i    ),
      .rd_en_i   ( tag_rd_en  ),
      .set_i     ( tag_set    ),
      .wr_way_i  ( tag_wr_way ),
      .wdata_i   ( tag_wdata  ),
      .flush_i   ( tag_flush  ),
      .tag_o     ( tag_rdata  ),
      .valid_o   ( tag_valid  )
   );

   icache_data_store
   #(
      .NB_WAYS   ( NB_WAYS     ),
      .SET_WIDTH ( SET_W       )
   )
   i_data_store
   (
      .clk       ( clk         ),
      .rd_en_i   ( data_rd_en  ),
      .set_i     ( data_set    ),
      .wr_way_i  ( data_wr_way ),
      .wdata_i   ( data_wdata  ),
      .rdata_o   ( data_rdata  )
   );

   // L2 response buffer, always drained
   refill_resp_fifo i_resp_fifo
   (
      .clk       ( clk              ),
      .rst_n_i   ( rst_n_i          ),
      .valid_i   ( refill_r_valid_i ),
      .data_i    ( refill_r_data_i  ),
      .valid_o   ( resp_valid       ),
      .data_o    ( resp_data        )
   );

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
/*
 Free-running testbench clock, low at time zero.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen
#(
   parameter real PERIOD_NS = 8.0   // Full clock period
)
(
   output logic clk_o
);

   initial
   begin
      clk_o = 1'b0;
      forever
         #(PERIOD_NS / 2.0) clk_o = ~clk_o;
   end

endmodule

`default_nettype wire

//--- tb_pri_icache.sv
/*
 Testbench for the instruction cache with default parameters. An L2 model stalls its
 grant and answers 1 to 4 cycles later. Every line word is its byte address XOR a key,
 so each fetch word is known from the address alone. One fetch is in flight at a time.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_pri_icache import icache_pkg::*; ();

   localparam int          NUM_RANDOM     = 12;
   localparam int          NUM_FETCHES    = 14 + NUM_RANDOM;       // Directed plus random
   localparam int          TIMEOUT_CYCLES = 40 * NUM_FETCHES + 200;
   localparam fetch_data_t DATA_KEY       = 32'hA5A5_0000;

   // Three lines in set 4, one line in set 8, and a random window
   localparam fetch_addr_t LINE_A      = 32'h0000_1040;
   localparam fetch_addr_t LINE_B      = 32'h0000_1240;
   localparam fetch_addr_t LINE_C      = 32'h0000_1440;
   localparam fetch_addr_t LINE_D      = 32'h0000_2080;
   localparam fetch_addr_t RANDOM_BASE = 32'h0000_4000;

   logic         clk;
   logic         rst_n;
   logic         fetch_req;
   fetch_addr_t  fetch_addr;
   logic         fetch_gnt;
   logic         fetch_rvalid;
   fetch_data_t  fetch_rdata;
   logic         refill_req;
   fetch_addr_t  refill_addr;
   logic         refill_gnt;
   logic         refill_r_valid;
   line_data_t   refill_r_data;
   logic         bypass;
   logic         flush;
   logic         is_bypassed;
   logic         is_flushed;

   // Expectations set by the stimulus, read by the assertions
   logic         expect_hit;
   logic         expect_miss;
   logic         flushed_known;
   logic         flushed_exp;
   logic         bypass_known;
   logic         bypass_exp;

   fetch_addr_t  gnt_addr;     // Last granted fetch address
   fetch_data_t  exp_word;
   integer       seed = 35;
   int           err_cnt = 0;
   int           fetch_cnt = 0;
   int           refill_cnt = 0;
   int           cycle_cnt = 0;

   tb_clk_gen #(.PERIOD_NS(8.0)) i_clk_gen (.clk_o(clk));

   pri_icache DUT
   (
      .clk                 ( clk            ),
      .rst_n_i             ( rst_n          ),
      .fetch_req_i         ( fetch_req      ),
      .fetch_addr_i        ( fetch_addr     ),
      .fetch_gnt_o         ( fetch_gnt      ),
      .fetch_rvalid_o      ( fetch_rvalid   ),
      .fetch_rdata_o       ( fetch_rdata    ),
      .refill_req_o        ( refill_req     ),
      .refill_addr_o       ( refill_addr    ),
      .refill_gnt_i        ( refill_gnt     ),
      .refill_r_valid_i    ( refill_r_valid ),
      .refill_r_data_i     ( refill_r_data  ),
      .bypass_icache_i     ( bypass         ),
      .flush_icache_i      ( flush          ),
      .cache_is_bypassed_o ( is_bypassed    ),
      .cache_is_flushed_o  ( is_flushed     )
   );

   // Line contents as the L2 holds them
   function automatic line_data_t make_line(input fetch_addr_t base);
      line_data_t line;
      for (int i = 0; i < 4; i++)
         line[i*32 +: 32] = (base + fetch_addr_t'(4 * i)) ^ DATA_KEY;
      return line;
   endfunction

   task automatic flag_error(input string msg);
      err_cnt++;
      $display("FAIL %0t: %s", $time, msg);
   endtask

   always @(posedge clk)
   begin
      if (fetch_gnt)
         gnt_addr <= fetch_addr;                      // Address of the fetch in flight
   end

   assign exp_word = {gnt_addr[31:2], 2'b00} ^ DATA_KEY;

   //////////////////////////////
   // Checks
   //////////////////////////////
   a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
      fetch_rvalid |-> (fetch_rdata == exp_word))
      else flag_error("fetch word differs from the line data rule");

   a_hit: assert property (@(posedge clk) disable iff (!rst_n)
      (fetch_gnt && expect_hit) |=> (fetch_rvalid && !refill_req))
      else flag_error("cached line did not return one cycle after grant");

   a_miss: assert property (@(posedge clk) disable iff (!rst_n)
      (fetch_gnt && expect_miss) |=> refill_req)
      else flag_error("expected refill request after grant");

   a_refill_addr: assert property (@(posedge clk) disable iff (!rst_n)
      refill_req |-> (refill_addr == {gnt_addr[31:4], 4'h0}))
      else flag_error("refill address is not the aligned fetch address");

   a_refill_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (refill_req && !refill_gnt) |=> (refill_req && $stable(refill_addr)))
      else flag_error("refill request dropped or moved under back-pressure");

   a_flushed: assert property (@(posedge clk) disable iff (!rst_n)
      flushed_known |-> (is_flushed == flushed_exp))
      else flag_error("flushed status wrong");

   a_bypassed: assert property (@(posedge clk) disable iff (!rst_n)
      bypass_known |-> (is_bypassed == bypass_exp))
      else flag_error("bypassed status wrong");

   // Outputs while reset is held, after the first edges
   a_reset: assert property (@(posedge clk)
      (!rst_n && cycle_cnt > 2) |->
         (!fetch_gnt && !fetch_rvalid && !refill_req && !is_bypassed && is_flushed))
      else flag_error("outputs wrong during reset");

   //////////////////////////////
   // L2 model
   //////////////////////////////
   initial
   begin : l2_model
      fetch_addr_t  line_addr;
      int           stall;
      int           resp_delay;
      refill_gnt     = 1'b0;
      refill_r_valid = 1'b0;
      refill_r_data  = '0;
      forever
      begin
         do
            @(negedge clk);
         while (!(rst_n && refill_req));
         line_addr  = refill_addr;
         stall      = $random(seed) & 3;              // Cycles with grant held low
         resp_delay = 1 + ($random(seed) & 3);
         repeat (stall) @(posedge clk);
         @(posedge clk);
         refill_gnt <= 1'b1;
         refill_cnt++;
         @(posedge clk);
         refill_gnt <= 1'b0;
         repeat (resp_delay - 1) @(posedge clk);
         refill_r_valid <= 1'b1;
         refill_r_data  <= make_line(line_addr);
         @(posedge clk);
         refill_r_valid <= 1'b0;
      end
   end

   // One fetch, request held until grant, then wait for the word
   task automatic fetch_word(input fetch_addr_t addr, input logic hit_exp, input logic miss_exp);
      @(posedge clk);
      fetch_req   <= 1'b1;
      fetch_addr  <= addr;
      expect_hit  <= hit_exp;
      expect_miss <= miss_exp;
      do
         @(negedge clk);
      while (!fetch_gnt);
      @(posedge clk);
      fetch_req <= 1'b0;
      do
         @(negedge clk);
      while (!fetch_rvalid);
      fetch_cnt++;
   endtask

   //////////////////////////////
   // Stimulus
   //////////////////////////////
   initial
   begin : stimulus
      fetch_addr_t addr;
      rst_n         = 1'b0;
      fetch_req     = 1'b0;
      fetch_addr    = '0;
      bypass        = 1'b0;
      flush         = 1'b0;
      expect_hit    = 1'b0;
      expect_miss   = 1'b0;
      flushed_known = 1'b0;
      flushed_exp   = 1'b0;
      bypass_known  = 1'b0;
      bypass_exp    = 1'b0;

      repeat (10) @(posedge clk);
      rst_n         <= 1'b1;
      flushed_known <= 1'b1;                          // Empty after reset
      flushed_exp   <= 1'b1;
      bypass_known  <= 1'b1;
      bypass_exp    <= 1'b0;
      repeat (3) @(posedge clk);
      flushed_known <= 1'b0;

      // Miss then hits on the same line
      fetch_word(LINE_A + 32'h4, 1'b0, 1'b1);
      fetch_word(LINE_A + 32'h8, 1'b1, 1'b0);
      fetch_word(LINE_A + 32'hC, 1'b1, 1'b0);

      // Third line in set 4 pushes A out
      fetch_word(LINE_B, 1'b0, 1'b1);
      fetch_word(LINE_C, 1'b0, 1'b1);
      fetch_word(LINE_A, 1'b0, 1'b1);
      fetch_word(LINE_C + 32'h4, 1'b1, 1'b0);

      ////////////////////////////// Flush
      @(posedge clk);
      flush <= 1'b1;
      do
         @(negedge clk);
      while (!is_flushed);
      @(posedge clk);
      flush         <= 1'b0;
      flushed_known <= 1'b1;
      flushed_exp   <= 1'b1;
      repeat (2) @(posedge clk);
      flushed_known <= 1'b0;
      fetch_word(LINE_A, 1'b0, 1'b1);                 // Was cached before the flush
      @(posedge clk);
      flushed_known <= 1'b1;
      flushed_exp   <= 1'b0;                          // First allocation done
      fetch_word(LINE_A + 32'h4, 1'b1, 1'b0);
      flushed_known <= 1'b0;

      ////////////////////////////// Bypass
      @(posedge clk);
      bypass       <= 1'b1;
      bypass_known <= 1'b0;
      repeat (2) @(posedge clk);
      bypass_known <= 1'b1;
      bypass_exp   <= 1'b1;
      fetch_word(LINE_D, 1'b0, 1'b1);
      fetch_word(LINE_D, 1'b0, 1'b1);                 // Repeat still goes to L2
      fetch_word(LINE_D + 32'h4, 1'b0, 1'b1);
      @(posedge clk);
      bypass       <= 1'b0;
      bypass_known <= 1'b0;
      repeat (2) @(posedge clk);
      bypass_known <= 1'b1;
      bypass_exp   <= 1'b0;
      fetch_word(LINE_D, 1'b0, 1'b1);                 // Never allocated under bypass
      fetch_word(LINE_D + 32'h8, 1'b1, 1'b0);

      // Random words in a 1 KiB window, data only
      for (int i = 0; i < NUM_RANDOM; i++)
      begin
         addr = RANDOM_BASE | ($random(seed) & 32'h0000_03FC);
         fetch_word(addr, 1'b0, 1'b0);
      end

      repeat (5) @(posedge clk);
      $display("Summary: %0d errors, %0d fetches, %0d refills", err_cnt, fetch_cnt, refill_cnt);
      if (err_cnt == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

   // Watchdog
   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("Timeout: no finish after %0d cycles, %0d fetches done",
                  TIMEOUT_CYCLES, fetch_cnt);
         $display("STATUS: FAIL");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- pri_icache.f
icache_pkg.sv
icache_tag_store.sv
icache_data_store.sv
refill_resp_fifo.sv
icache_controller.sv
pri_icache.sv
tb_clk_gen.sv
tb_pri_icache.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert --timing -Wno-fatal
TOP       = tb_pri_icache
FILELIST  = pri_icache.f
OBJ_DIR   = obj_dir
PASS_MSG  = STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
